// ==== common/clock_pkg.sv ====
`default_nettype none

package clock_pkg;

    // Mode ring order is run, seconds, minutes, hours
    typedef enum logic [1:0] {
        MODE_RUN    = 2'd0,
        MODE_SET_SS = 2'd1,
        MODE_SET_MM = 2'd2,
        MODE_SET_HH = 2'd3
    } mode_t;

    // One decimal digit
    typedef logic [3:0] bcd_t;

    // Largest tens digit per field
    localparam bcd_t MAX_TENS_MS = 4'd5;   // 59 for minutes and seconds
    localparam bcd_t MAX_TENS_H  = 4'd2;   // 23 for hours

endpackage

`default_nettype wire

// ==== common/seg_pkg.sv ====
`default_nettype none

package seg_pkg;

    // Segment a in bit 0 up to g in bit 6, active high
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_BLANK = 7'h00;

    function automatic seg_t digit_to_seg(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h40;   // Dash for an illegal digit
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hw/button_pulse.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_pulse (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic pulse
);

    logic sync1;
    logic sync2;
    logic prev;    // Synchronised level one cycle back

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
            prev  <= 1'b0;
            pulse <= 1'b0;
        end else begin
            sync1 <= button;
            sync2 <= sync1;
            prev  <= sync2;
            // Registered so the pulse lands in the third cycle
            pulse <= sync2 & ~prev;
        end
    end

    // A held button must not give back-to-back pulses
    a_pulse_single: assert property (
        @(posedge clk) disable iff (!rst)
        pulse |=> !pulse
    );

endmodule

`default_nettype wire

// ==== hw/mode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                mode_pulse,
    output clock_pkg::mode_t    mode,
    output logic                led_hh,
    output logic                led_mm,
    output logic                led_ss
);

    clock_pkg::mode_t mode_next;

    // Next mode in the ring
    always_comb begin
        case (mode)
            clock_pkg::MODE_RUN:    mode_next = clock_pkg::MODE_SET_SS;
            clock_pkg::MODE_SET_SS: mode_next = clock_pkg::MODE_SET_MM;
            clock_pkg::MODE_SET_MM: mode_next = clock_pkg::MODE_SET_HH;
            default:                mode_next = clock_pkg::MODE_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode <= clock_pkg::MODE_RUN;
        end else if (mode_pulse) begin
            mode <= mode_next;
        end
    end

    // One LED per set mode, all dark while running
    assign led_ss = (mode == clock_pkg::MODE_SET_SS);
    assign led_mm = (mode == clock_pkg::MODE_SET_MM);
    assign led_hh = (mode == clock_pkg::MODE_SET_HH);

    a_led_onehot0: assert property (
        @(posedge clk) disable iff (!rst)
        $onehot0({led_hh, led_mm, led_ss})
    );

endmodule

`default_nettype wire

// ==== timekeeper/time_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_counter #(
    parameter int TICKS_PER_SEC = 50000000
) (
    input  logic                clk,
    input  logic                rst,
    input  clock_pkg::mode_t    mode,
    input  logic                inc_pulse,
    output clock_pkg::bcd_t     h_ten,
    output clock_pkg::bcd_t     h_unit,
    output clock_pkg::bcd_t     m_ten,
    output clock_pkg::bcd_t     m_unit,
    output clock_pkg::bcd_t     s_ten,
    output clock_pkg::bcd_t     s_unit
);

    localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [CNT_W-1:0] PRESC_LAST = CNT_W'(TICKS_PER_SEC - 1);

    localparam clock_pkg::bcd_t UNIT_MAX    = 4'd9;
    localparam clock_pkg::bcd_t LAST_H_UNIT = 4'd3;   // Unit digit of 23

    logic [CNT_W-1:0] presc;

    // Carry in bit 8, then tens and units
    logic [8:0] s_next;
    logic [8:0] m_next;
    logic [8:0] h_next;

    // Advance a digit pair, wrap to 00 after max_ten:max_unit
    function automatic logic [8:0] bump_pair(
        input clock_pkg::bcd_t ten,
        input clock_pkg::bcd_t unit,
        input clock_pkg::bcd_t max_ten,
        input clock_pkg::bcd_t max_unit
    );
        if (ten == max_ten && unit == max_unit) begin
            return {1'b1, 4'd0, 4'd0};
        end else if (unit == UNIT_MAX) begin
            return {1'b0, ten + 4'd1, 4'd0};
        end else begin
            return {1'b0, ten, unit + 4'd1};
        end
    endfunction

    assign s_next = bump_pair(s_ten, s_unit, clock_pkg::MAX_TENS_MS, UNIT_MAX);
    assign m_next = bump_pair(m_ten, m_unit, clock_pkg::MAX_TENS_MS, UNIT_MAX);
    assign h_next = bump_pair(h_ten, h_unit, clock_pkg::MAX_TENS_H, LAST_H_UNIT);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            presc  <= '0;
            h_ten  <= 4'd0;
            h_unit <= 4'd0;
            m_ten  <= 4'd0;
            m_unit <= 4'd0;
            s_ten  <= 4'd0;
            s_unit <= 4'd0;
        end else if (mode == clock_pkg::MODE_RUN) begin
            if (presc == PRESC_LAST) begin
                presc <= '0;
                {s_ten, s_unit} <= s_next[7:0];
                // Full ripple within this one edge
                if (s_next[8]) begin
                    {m_ten, m_unit} <= m_next[7:0];
                    if (m_next[8]) begin
                        {h_ten, h_unit} <= h_next[7:0];
                    end
                end
            end else begin
                presc <= presc + 1'b1;
            end
        end else begin
            presc <= '0;   // Clock stands still while setting
            if (inc_pulse) begin
                // Carry bit dropped, the field wraps alone
                case (mode)
                    clock_pkg::MODE_SET_SS: {s_ten, s_unit} <= s_next[7:0];
                    clock_pkg::MODE_SET_MM: {m_ten, m_unit} <= m_next[7:0];
                    clock_pkg::MODE_SET_HH: {h_ten, h_unit} <= h_next[7:0];
                    default: ;
                endcase
            end
        end
    end

    a_digit_range: assert property (
        @(posedge clk) disable iff (!rst)
        s_unit <= UNIT_MAX && m_unit <= UNIT_MAX && h_unit <= UNIT_MAX &&
        s_ten <= clock_pkg::MAX_TENS_MS && m_ten <= clock_pkg::MAX_TENS_MS &&
        h_ten <= clock_pkg::MAX_TENS_H
    );

    a_hours_max: assert property (
        @(posedge clk) disable iff (!rst)
        h_ten == clock_pkg::MAX_TENS_H |-> h_unit <= LAST_H_UNIT
    );

endmodule

`default_nettype wire

// ==== hw/seg_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_display (
    input  clock_pkg::mode_t    mode,
    input  clock_pkg::bcd_t     h_ten,
    input  clock_pkg::bcd_t     h_unit,
    input  clock_pkg::bcd_t     m_ten,
    input  clock_pkg::bcd_t     m_unit,
    input  clock_pkg::bcd_t     s_ten,
    input  clock_pkg::bcd_t     s_unit,
    output seg_pkg::seg_t       seg_h_ten,
    output seg_pkg::seg_t       seg_h_unit,
    output seg_pkg::seg_t       seg_m_ten,
    output seg_pkg::seg_t       seg_m_unit,
    output seg_pkg::seg_t       seg_s_ten,
    output seg_pkg::seg_t       seg_s_unit
);

    logic show_h;
    logic show_m;
    logic show_s;

    // Run mode lights everything, a set mode only its own pair
    assign show_h = (mode == clock_pkg::MODE_RUN) || (mode == clock_pkg::MODE_SET_HH);
    assign show_m = (mode == clock_pkg::MODE_RUN) || (mode == clock_pkg::MODE_SET_MM);
    assign show_s = (mode == clock_pkg::MODE_RUN) || (mode == clock_pkg::MODE_SET_SS);

    assign seg_h_ten  = show_h ? seg_pkg::digit_to_seg(h_ten)  : seg_pkg::SEG_BLANK;
    assign seg_h_unit = show_h ? seg_pkg::digit_to_seg(h_unit) : seg_pkg::SEG_BLANK;

    assign seg_m_ten  = show_m ? seg_pkg::digit_to_seg(m_ten)  : seg_pkg::SEG_BLANK;
    assign seg_m_unit = show_m ? seg_pkg::digit_to_seg(m_unit) : seg_pkg::SEG_BLANK;

    assign seg_s_ten  = show_s ? seg_pkg::digit_to_seg(s_ten)  : seg_pkg::SEG_BLANK;
    assign seg_s_unit = show_s ? seg_pkg::digit_to_seg(s_unit) : seg_pkg::SEG_BLANK;

endmodule

`default_nettype wire

// ==== hw/clock_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_top #(
    parameter int TICKS_PER_SEC = 50000000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            mode_button,
    input  logic            increase_button,
    output seg_pkg::seg_t   seg_h_ten,
    output seg_pkg::seg_t   seg_h_unit,
    output seg_pkg::seg_t   seg_m_ten,
    output seg_pkg::seg_t   seg_m_unit,
    output seg_pkg::seg_t   seg_s_ten,
    output seg_pkg::seg_t   seg_s_unit,
    output logic            led_hh,
    output logic            led_mm,
    output logic            led_ss
);

    logic mode_pulse;
    logic inc_pulse;

    clock_pkg::mode_t mode;

    clock_pkg::bcd_t h_ten, h_unit;
    clock_pkg::bcd_t m_ten, m_unit;
    clock_pkg::bcd_t s_ten, s_unit;

    // Raw button levels to single-cycle pulses
    button_pulse u_mode_btn (
        .clk    (clk),
        .rst    (rst),
        .button (mode_button),
        .pulse  (mode_pulse)
    );

    button_pulse u_inc_btn (
        .clk    (clk),
        .rst    (rst),
        .button (increase_button),
        .pulse  (inc_pulse)
    );

    mode_ctrl u_mode_ctrl (
        .clk        (clk),
        .rst        (rst),
        .mode_pulse (mode_pulse),
        .mode       (mode),
        .led_hh     (led_hh),
        .led_mm     (led_mm),
        .led_ss     (led_ss)
    );

    time_counter #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_time_counter (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .inc_pulse (inc_pulse),
        .h_ten     (h_ten),
        .h_unit    (h_unit),
        .m_ten     (m_ten),
        .m_unit    (m_unit),
        .s_ten     (s_ten),
        .s_unit    (s_unit)
    );

    seg_display u_seg_display (
        .mode       (mode),
        .h_ten      (h_ten),
        .h_unit     (h_unit),
        .m_ten      (m_ten),
        .m_unit     (m_unit),
        .s_ten      (s_ten),
        .s_unit     (s_unit),
        .seg_h_ten  (seg_h_ten),
        .seg_h_unit (seg_h_unit),
        .seg_m_ten  (seg_m_ten),
        .seg_m_unit (seg_m_unit),
        .seg_s_ten  (seg_s_ten),
        .seg_s_unit (seg_s_unit)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock;

    localparam int TICKS        = 5;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int PRESS_CYCLES = 7;    // Edge, 2 high, 4 settle

    // Worst-case run length in cycles
    localparam int RESET_TOTAL = 5 * (RESET_CYCLES + 10);
    localparam int PRESS_TOTAL = (3 + 286 + 1 + 300 + 1) * PRESS_CYCLES;
    localparam int WAIT_TOTAL  = 9 * TICKS + 25 + 30;
    localparam int WATCHDOG_NS = 2 * (RESET_TOTAL + PRESS_TOTAL + WAIT_TOTAL) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic mode_button;
    logic increase_button;

    seg_pkg::seg_t seg_h_ten;
    seg_pkg::seg_t seg_h_unit;
    seg_pkg::seg_t seg_m_ten;
    seg_pkg::seg_t seg_m_unit;
    seg_pkg::seg_t seg_s_ten;
    seg_pkg::seg_t seg_s_unit;
    logic          led_hh;
    logic          led_mm;
    logic          led_ss;

    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    // Reference time and mode
    int               model_h;
    int               model_m;
    int               model_s;
    clock_pkg::mode_t model_mode;

    clock_top #(
        .TICKS_PER_SEC (TICKS)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .mode_button     (mode_button),
        .increase_button (increase_button),
        .seg_h_ten       (seg_h_ten),
        .seg_h_unit      (seg_h_unit),
        .seg_m_ten       (seg_m_ten),
        .seg_m_unit      (seg_m_unit),
        .seg_s_ten       (seg_s_ten),
        .seg_s_unit      (seg_s_unit),
        .led_hh          (led_hh),
        .led_mm          (led_mm),
        .led_ss          (led_ss)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA3000000;   // Taps 32, 30, 26, 25
        end else begin
            return state >> 1;
        end
    endfunction

    // Seven LFSR bits folded into 0 to 99
    task automatic draw_press_count(output int count);
        logic [6:0] bits;
        int         i;
        for (i = 0; i < 7; i++) begin
            bits[i]    = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        count = int'(bits) % 100;
    endtask

    function automatic clock_pkg::mode_t next_mode(input clock_pkg::mode_t m);
        case (m)
            clock_pkg::MODE_RUN:    return clock_pkg::MODE_SET_SS;
            clock_pkg::MODE_SET_SS: return clock_pkg::MODE_SET_MM;
            clock_pkg::MODE_SET_MM: return clock_pkg::MODE_SET_HH;
            default:                return clock_pkg::MODE_RUN;
        endcase
    endfunction

    // Standard seven-segment shapes in gfedcba order
    function automatic seg_pkg::seg_t expected_seg(input logic show, input int digit);
        if (!show) begin
            return 7'b0000000;   // Pair blanked
        end
        case (digit)
            0:       return 7'b0111111;
            1:       return 7'b0000110;
            2:       return 7'b1011011;
            3:       return 7'b1001111;
            4:       return 7'b1100110;
            5:       return 7'b1101101;
            6:       return 7'b1111101;
            7:       return 7'b0000111;
            8:       return 7'b1111111;
            9:       return 7'b1101111;
            default: return 7'b1000000;
        endcase
    endfunction

    // One second of the model with full carry
    task automatic model_tick();
        model_s = model_s + 1;
        if (model_s == 60) begin
            model_s = 0;
            model_m = model_m + 1;
            if (model_m == 60) begin
                model_m = 0;
                model_h = (model_h + 1) % 24;
            end
        end
    endtask

    task automatic check_seg(input string test, input string field,
                             input seg_pkg::seg_t expected, input seg_pkg::seg_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic check_led(input string test, input logic [2:0] expected,
                             input logic [2:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s leds hh/mm/ss: expected %b, actual %b",
                     test, expected, actual);
        end
    endtask

    // Sampled mid-cycle away from the rising edge
    task automatic check_display(input string test);
        logic run;
        logic show_h;
        logic show_m;
        logic show_s;
        run    = (model_mode == clock_pkg::MODE_RUN);
        show_h = run || (model_mode == clock_pkg::MODE_SET_HH);
        show_m = run || (model_mode == clock_pkg::MODE_SET_MM);
        show_s = run || (model_mode == clock_pkg::MODE_SET_SS);
        @(negedge clk);
        check_seg(test, "h_ten",  expected_seg(show_h, model_h / 10), seg_h_ten);
        check_seg(test, "h_unit", expected_seg(show_h, model_h % 10), seg_h_unit);
        check_seg(test, "m_ten",  expected_seg(show_m, model_m / 10), seg_m_ten);
        check_seg(test, "m_unit", expected_seg(show_m, model_m % 10), seg_m_unit);
        check_seg(test, "s_ten",  expected_seg(show_s, model_s / 10), seg_s_ten);
        check_seg(test, "s_unit", expected_seg(show_s, model_s % 10), seg_s_unit);
        check_led(test, {show_h && !run, show_m && !run, show_s && !run},
                  {led_hh, led_mm, led_ss});
    endtask

    task automatic press_button(input logic on_inc);
        @(posedge clk);
        if (on_inc) begin
            increase_button <= 1'b1;
        end else begin
            mode_button <= 1'b1;
        end
        repeat (2) @(posedge clk);
        increase_button <= 1'b0;
        mode_button     <= 1'b0;
        repeat (4) @(posedge clk);   // Pulse and register update land here
    endtask

    task automatic press_mode();
        press_button(1'b0);
        model_mode = next_mode(model_mode);
    endtask

    // Set-mode increments where each field wraps alone
    task automatic press_inc(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            press_button(1'b1);
        end
        case (model_mode)
            clock_pkg::MODE_SET_SS: model_s = (model_s + count) % 60;
            clock_pkg::MODE_SET_MM: model_m = (model_m + count) % 60;
            clock_pkg::MODE_SET_HH: model_h = (model_h + count) % 24;
            default: ;
        endcase
    endtask

    task automatic apply_reset(input logic hold_mode);
        @(posedge clk);
        rst             <= 1'b0;
        mode_button     <= hold_mode;
        increase_button <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst        <= 1'b1;
        model_h    = 0;
        model_m    = 0;
        model_s    = 0;
        model_mode = clock_pkg::MODE_RUN;
        if (hold_mode) begin
            // Held button rises after reset and set mode arrives before the first tick
            repeat (4) @(posedge clk);
            mode_button <= 1'b0;
            repeat (4) @(posedge clk);
            model_mode = clock_pkg::MODE_SET_SS;
        end
    endtask

    task automatic test_reset();
        apply_reset(1'b0);
        check_display("reset");
    endtask

    task automatic test_mode_walk();
        apply_reset(1'b1);
        check_display("mode_walk");
        repeat (3) begin
            press_mode();
            check_display("mode_walk");
        end
    endtask

    // Ends in hours set mode at 23:59:58
    task automatic test_set_wrap();
        apply_reset(1'b1);
        press_inc(58);
        check_display("set_wrap");
        press_inc(60);
        check_display("set_wrap");
        press_mode();
        check_display("set_wrap");   // Minutes untouched by the seconds wrap
        press_inc(59);
        check_display("set_wrap");
        press_inc(60);
        check_display("set_wrap");
        press_mode();
        check_display("set_wrap");
        press_inc(23);
        check_display("set_wrap");
        press_inc(24);
        check_display("set_wrap");
    endtask

    task automatic test_run_carry();
        press_mode();
        // Two run edges already passed inside the press so checks fall mid-second
        repeat (2 * TICKS) @(posedge clk);
        model_tick();
        model_tick();
        check_display("run_carry");
        repeat (7 * TICKS) @(posedge clk);
        repeat (7) model_tick();
        check_display("run_carry");
    endtask

    task automatic test_random_set();
        int count;
        apply_reset(1'b1);
        draw_press_count(count);
        press_inc(count);
        check_display("random_set");
        press_mode();
        check_display("random_set");
        draw_press_count(count);
        press_inc(count);
        check_display("random_set");
        press_mode();
        check_display("random_set");
        draw_press_count(count);
        press_inc(count);
        check_display("random_set");
        press_mode();
        check_display("random_set");   // All three fields back in view
    endtask

    task automatic test_held_button();
        apply_reset(1'b1);
        @(posedge clk);
        increase_button <= 1'b1;
        repeat (20) @(posedge clk);
        increase_button <= 1'b0;
        repeat (4) @(posedge clk);
        model_s = 1;
        check_display("held_button");
        press_inc(1);
        check_display("held_button");
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        lfsr_state      = 32'h05343621;
        rst             = 1'b0;
        mode_button     = 1'b0;
        increase_button = 1'b0;
        model_h         = 0;
        model_m         = 0;
        model_s         = 0;
        model_mode      = clock_pkg::MODE_RUN;

        test_reset();
        test_mode_walk();
        test_set_wrap();
        test_run_carry();
        test_random_set();
        test_held_button();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/clock_pkg.sv
common/seg_pkg.sv
hw/button_pulse.sv
hw/mode_ctrl.sv
timekeeper/time_counter.sv
hw/seg_display.sv
hw/clock_top.sv
verif/tb_clock.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_clock -f src.f -Mdir obj_dir -o tb_clock_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_clock_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
